//--- build.f
+incdir+hdl
hdl/lsu_pkg.sv
hdl/lsu_align.sv
hdl/lsu_skid_buffer.sv
hdl/lsu_wb_master.sv
hdl/lsu_data_mem.sv
hdl/lsu_load_extract.sv
hdl/lsu_top.sv
sim/lsu_assertions.sv
sim/lsu_checker.sv
sim/lsu_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f build.f --top-module lsu_tb -o lsu_sim || exit 1
out=$(./obj_dir/lsu_sim +verilator+error+limit+100)
echo "$out"
echo "$out" | grep -qx "Everything OK" && echo "simulation passed" || {
    echo "simulation did not pass"
    exit 1
}

//--- sim/lsu_tb.sv
`timescale 1ns/1ns

`include "lsu_consts.svh"

module lsu_tb;
    import lsu_pkg::*;

    localparam int WAIT_LIMIT = 2000;

    logic        clk;
    logic        arst_n;
    logic        req_valid;
    logic        req_ready;
    lsu_req_t    req;
    logic        rsp_valid;
    logic        rsp_ready;
    lsu_rsp_t    rsp;
    logic [31:0] io_in;
    logic [31:0] lfsr;
    logic [31:0] ready_lfsr;
    logic        random_ready;
    logic        hung;
    int          err_count;
    int          check_count;
    int          pending;
    int          err_before;
    int          tests_run;

    lsu_top UUT (.*);

    lsu_checker u_checker (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // random source
    ////////////////////////////////////////////////////////////////////////////

    // taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    always @(negedge clk)
    begin
        ready_lfsr = lfsr_step(ready_lfsr);
        rsp_ready  = random_ready ? ready_lfsr[0] : 1'b1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    // called on a falling edge, returns on the one after the transfer.
    task automatic issue(lsu_op_e op, logic [31:0] addr, logic [31:0] wdata);
        int n;
        n         = 0;
        req_valid = 1'b1;
        req.op    = op;
        req.addr  = addr;
        req.wdata = wdata;
        while (!req_ready && !hung)
        begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT)
            begin
                $display("%0t: request was never accepted", $time);
                hung = 1'b1;
            end
        end
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (pending != 0 && !hung)
        begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT)
            begin
                $display("%0t: %0d responses never arrived", $time, pending);
                hung = 1'b1;
            end
        end
    endtask

    task automatic end_test(string name);
        wait_idle();
        tests_run++;
        if (err_count == err_before && !hung)
            $display("test %0d %s: pass", tests_run, name);
        else
            $display("test %0d %s: FAIL, %0d errors", tests_run, name, err_count - err_before);
        err_before = err_count;
    endtask

    task automatic fill_words(logic [31:0] base, int words);
        for (int i = 0; i < words; i++)
            issue(SW, base + 4 * i, take_bits(32));
    endtask

    task automatic random_ops(logic [31:0] base, int count);
        logic [31:0] r;
        logic [31:0] a;
        for (int i = 0; i < count; i++)
        begin
            r = take_bits(3);
            a = base + take_bits(6);
            issue(lsu_op_e'(r[2:0]), a, take_bits(32));
        end
    endtask

    initial
    begin
        logic [31:0] a;
        int          total;
        arst_n       = 1'b0;
        req_valid    = 1'b0;
        req          = '0;
        rsp_ready    = 1'b1;
        io_in        = '0;
        lfsr         = 32'd97111;
        ready_lfsr   = 32'd97111;
        random_ready = 1'b0;
        hung         = 1'b0;
        err_before   = 0;
        tests_run    = 0;
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        for (int i = 0; i < 4; i++)
        begin
            a = take_bits(10) << 2;
            issue(SW, a, take_bits(32));
            issue(LW, a, 32'h0);
        end
        end_test("store and load word");

        issue(SW, 32'h200, 32'h0);
        issue(SB, 32'h200, 32'h85);
        issue(SB, 32'h201, 32'h7f);
        issue(SH, 32'h202, 32'hf00d); // word is f00d7f85.
        for (int k = 0; k < 4; k++)
        begin
            issue(LB, 32'h200 + k, 32'h0);
            issue(LBU, 32'h200 + k, 32'h0);
        end
        issue(LH, 32'h200, 32'h0);
        issue(LH, 32'h202, 32'h0);
        issue(LHU, 32'h202, 32'h0);
        issue(LW, 32'h200, 32'h0);
        end_test("byte and halfword merge");

        issue(SW, 32'h300, 32'h11223344);
        issue(SH, 32'h301, 32'hffff);
        issue(SW, 32'h302, 32'hffffffff);
        issue(LH, 32'h303, 32'h0);
        issue(LW, 32'h301, 32'h0);
        issue(LW, 32'h300, 32'h0);
        end_test("misaligned faults");

        io_in = 32'h8a5cf0e1;
        issue(SW, 32'h0, 32'h01020304);
        issue(SW, `LSU_IO_BASE, 32'hdeadbeef); // aliases word 0, must be dropped.
        issue(LW, `LSU_IO_BASE, 32'h0);
        for (int k = 0; k < 4; k++)
        begin
            issue(LB, `LSU_IO_BASE + k, 32'h0);
            issue(LBU, `LSU_IO_BASE + k, 32'h0);
        end
        issue(LH, `LSU_IO_BASE + 2, 32'h0);
        issue(LHU, `LSU_IO_BASE, 32'h0);
        issue(LW, 32'h0, 32'h0);
        wait_idle();
        io_in = 32'h7f00ff80;
        issue(LH, `LSU_IO_BASE, 32'h0);
        issue(LW, `LSU_IO_BASE + 4, 32'h0);
        end_test("io window");

        fill_words(32'h400, 16);
        random_ready = 1'b1;
        random_ops(32'h400, 40);
        end_test("random back-pressure");
        random_ready = 1'b0;

        fill_words(32'h500, 16);
        random_ops(32'h500, 200);
        end_test("random mix");

        total = err_count + UUT.u_assert.fail_count;
        $display("tests %0d, responses checked %0d, errors %0d, hung %0d",
                 tests_run, check_count, total, hung);
        if (total == 0 && !hung)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

//--- sim/lsu_checker.sv
`timescale 1ns/1ns

`include "lsu_consts.svh"

module lsu_checker (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              req_valid,
    input  logic              req_ready,
    input  lsu_pkg::lsu_req_t req,
    input  logic              rsp_valid,
    input  logic              rsp_ready,
    input  lsu_pkg::lsu_rsp_t rsp,
    input  logic [31:0]       io_in,
    output int                err_count,
    output int                check_count,
    output int                pending
);
    import lsu_pkg::*;

    localparam int MEM_BYTES = `LSU_MEM_WORDS * 4;

    logic [7:0] ref_mem [MEM_BYTES];
    lsu_rsp_t   expected [$];
    lsu_rsp_t   exp_rsp;

    initial
    begin
        err_count   = 0;
        check_count = 0;
        pending     = 0;
    end

    // expected response of one request, from the access rules.
    function automatic lsu_rsp_t ref_response(lsu_req_t r);
        lsu_rsp_t    res;
        logic [31:0] word;
        logic [7:0]  b;
        logic [15:0] h;
        int          base;
        res = '0;
        case (r.op)
            LH, LHU, SH: res.fault = r.addr[0];
            LW, SW:      res.fault = (r.addr[1:0] != 2'b00);
            default:     res.fault = 1'b0;
        endcase
        if (res.fault || r.op inside {SB, SH, SW})
            return res; // data stays zero.
        base = int'(r.addr % MEM_BYTES) & ~3;
        if (r.addr >= `LSU_IO_BASE)
            word = io_in;
        else
            word = {ref_mem[base + 3], ref_mem[base + 2], ref_mem[base + 1], ref_mem[base]};
        b = word[8 * r.addr[1:0] +: 8];
        h = word[16 * r.addr[1] +: 16];
        case (r.op)
            LB:      res.data = {{24{b[7]}}, b};
            LH:      res.data = {{16{h[15]}}, h};
            LBU:     res.data = {24'h0, b};
            LHU:     res.data = {16'h0, h};
            default: res.data = word;
        endcase
        return res;
    endfunction

    task automatic apply_store(lsu_req_t r);
        int idx;
        int n;
        idx = int'(r.addr % MEM_BYTES);
        case (r.op)
            SB:      n = 1;
            SH:      n = 2;
            SW:      n = 4;
            default: n = 0;
        endcase
        if (r.addr >= `LSU_IO_BASE)
            n = 0; // port window is read only.
        for (int k = 0; k < n; k++)
            ref_mem[idx + k] = r.wdata[8 * k +: 8];
    endtask

    always @(posedge clk)
    begin
        if (!arst_n)
            expected.delete();
        else
        begin
            if (req_valid && req_ready)
            begin
                exp_rsp = ref_response(req);
                if (!exp_rsp.fault)
                    apply_store(req);
                expected.push_back(exp_rsp);
            end
            if (rsp_valid && rsp_ready)
            begin
                if (expected.size() == 0)
                begin
                    $display("%0t: response arrived with no request outstanding", $time);
                    err_count++;
                end
                else
                begin
                    exp_rsp = expected.pop_front();
                    check_count++;
                    if (rsp.data !== exp_rsp.data)
                    begin
                        $display("ERR %0t rsp.data expected %h actual %h",
                                 $time, exp_rsp.data, rsp.data);
                        err_count++;
                    end
                    if (rsp.fault !== exp_rsp.fault)
                    begin
                        $display("ERR %0t rsp.fault expected %b actual %b",
                                 $time, exp_rsp.fault, rsp.fault);
                        err_count++;
                    end
                end
            end
        end
        pending = expected.size();
    end

endmodule

//--- sim/lsu_assertions.sv
`timescale 1ns/1ns

module lsu_assertions (
    input logic              clk,
    input logic              arst_n,
    input logic              req_valid,
    input logic              req_ready,
    input lsu_pkg::lsu_req_t req,
    input logic              rsp_valid,
    input logic              rsp_ready,
    input lsu_pkg::lsu_rsp_t rsp,
    input logic              wb_cyc,
    input logic              wb_stb,
    input logic              wb_ack
);
    int fail_count = 0;

    ////////////////////////////////////////////////////////////////////////////
    // wishbone
    ////////////////////////////////////////////////////////////////////////////

    // strobe and cycle stay up until the slave acks.
    a_stb_cyc: assert property (@(posedge clk) disable iff (!arst_n)
        wb_stb && !wb_ack |=> wb_stb && wb_cyc)
    else
    begin
        fail_count++;
        $error("wb_stb or wb_cyc dropped before wb_ack");
    end

    a_ack_stb: assert property (@(posedge clk) disable iff (!arst_n) wb_ack |-> wb_stb)
    else
    begin
        fail_count++;
        $error("wb_ack high without wb_stb");
    end

    ////////////////////////////////////////////////////////////////////////////
    // core side handshakes
    ////////////////////////////////////////////////////////////////////////////

    a_rsp_hold: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
    else
    begin
        fail_count++;
        $error("rsp dropped or changed while stalled");
    end

    a_req_hold: assert property (@(posedge clk) disable iff (!arst_n)
        req_valid && !req_ready |=> req_valid && $stable(req))
    else
    begin
        fail_count++;
        $error("req dropped or changed while stalled");
    end

endmodule

bind lsu_top lsu_assertions u_assert (
    .clk       (clk),
    .arst_n    (arst_n),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_ack    (wb_ack)
);

//--- hdl/lsu_top.sv
`timescale 1ns/1ns

`include "lsu_consts.svh"

module lsu_top (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 req_valid,
    output logic                 req_ready,
    input  lsu_pkg::lsu_req_t    req,
    output logic                 rsp_valid,
    input  logic                 rsp_ready,
    output lsu_pkg::lsu_rsp_t    rsp,
    input  logic [`LSU_XLEN-1:0] io_in
);
    import lsu_pkg::*;

    lsu_bus_req_t align_req;
    logic         align_valid;
    logic         align_ready;
    lsu_bus_req_t mst_req;
    logic         mst_req_valid;
    logic         mst_req_ready;
    lsu_bus_rsp_t mst_rsp;
    logic         mst_rsp_valid;
    logic         mst_rsp_ready;
    lsu_bus_rsp_t ext_rsp;
    logic         ext_valid;
    logic         ext_ready;

    // wishbone between master and memory.
    logic         wb_cyc;
    logic         wb_stb;
    logic         wb_we;
    logic [29:0]  wb_adr;
    logic [3:0]   wb_sel;
    logic [31:0]  wb_dat_w;
    logic [31:0]  wb_dat_r;
    logic         wb_ack;

    lsu_align u_align (
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in_req    (req),
        .out_valid (align_valid),
        .out_ready (align_ready),
        .out_req   (align_req)
    );

    lsu_skid_buffer #(.payload_t(lsu_bus_req_t)) u_req_skid (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (align_valid),
        .in_ready  (align_ready),
        .in_data   (align_req),
        .out_valid (mst_req_valid),
        .out_ready (mst_req_ready),
        .out_data  (mst_req)
    );

    lsu_wb_master u_wb_master (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (mst_req_valid),
        .in_ready  (mst_req_ready),
        .in_req    (mst_req),
        .out_valid (mst_rsp_valid),
        .out_ready (mst_rsp_ready),
        .out_rsp   (mst_rsp),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_sel    (wb_sel),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack)
    );

    lsu_data_mem u_data_mem (
        .clk       (clk),
        .arst_n    (arst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_sel    (wb_sel),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .io_in     (io_in)
    );

    lsu_skid_buffer #(.payload_t(lsu_bus_rsp_t)) u_rsp_skid (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (mst_rsp_valid),
        .in_ready  (mst_rsp_ready),
        .in_data   (mst_rsp),
        .out_valid (ext_valid),
        .out_ready (ext_ready),
        .out_data  (ext_rsp)
    );

    lsu_load_extract u_load_extract (
        .in_valid  (ext_valid),
        .in_ready  (ext_ready),
        .in_rsp    (ext_rsp),
        .out_valid (rsp_valid),
        .out_ready (rsp_ready),
        .out_rsp   (rsp)
    );

endmodule

//--- hdl/lsu_load_extract.sv
`timescale 1ns/1ns

module lsu_load_extract (
    input  logic                  in_valid,
    output logic                  in_ready,
    input  lsu_pkg::lsu_bus_rsp_t in_rsp,
    output logic                  out_valid,
    input  logic                  out_ready,
    output lsu_pkg::lsu_rsp_t     out_rsp
);
    import lsu_pkg::*;

    logic [7:0]  byte_val;
    logic [15:0] half_val;
    logic [31:0] word_shift;

    assign out_valid = in_valid;
    assign in_ready  = out_ready;

    // move the addressed lane down to bit 0.
    assign word_shift = in_rsp.rdata >> {in_rsp.offset, 3'b000};
    assign byte_val   = word_shift[7:0];
    assign half_val   = word_shift[15:0];

    always_comb
    begin
        out_rsp.fault = in_rsp.fault;
        if (in_rsp.fault)
            out_rsp.data = '0;
        else
        begin
            case (in_rsp.op)
                LB:
                    out_rsp.data = {{24{byte_val[7]}}, byte_val};
                LH:
                    out_rsp.data = {{16{half_val[15]}}, half_val};
                LW:
                    out_rsp.data = in_rsp.rdata;
                LBU:
                    out_rsp.data = {24'b0, byte_val};
                LHU:
                    out_rsp.data = {16'b0, half_val};
                default:
                    out_rsp.data = '0; // stores.
            endcase
        end
    end

endmodule

//--- hdl/lsu_data_mem.sv
`timescale 1ns/1ns

`include "lsu_consts.svh"

module lsu_data_mem (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [29:0]          wb_adr,
    input  logic [3:0]           wb_sel,
    input  logic [31:0]          wb_dat_w,
    output logic [31:0]          wb_dat_r,
    output logic                 wb_ack,
    input  logic [`LSU_XLEN-1:0] io_in
);
    localparam int IDX_W = $clog2(`LSU_MEM_WORDS);

    // word memory, one entry per lane.
    logic [3:0][7:0]   mem [`LSU_MEM_WORDS];
    logic [IDX_W-1:0]  idx;
    logic              is_io;
    logic              access;

    assign idx    = wb_adr[IDX_W-1:0]; // wraps modulo depth.
    assign is_io  = ({wb_adr, 2'b00} >= `LSU_IO_BASE);
    assign access = wb_cyc && wb_stb && !wb_ack;

    ////////////////////////////////////////////////////////////////////////////
    // ack, one cycle per strobe
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            wb_ack <= 1'b0;
        else
            wb_ack <= access;
    end

    ////////////////////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (access && wb_we && !is_io)
        begin
            for (int lane = 0; lane < 4; lane++)
            begin
                if (wb_sel[lane])
                    mem[idx][lane] <= wb_dat_w[lane*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (access)
            wb_dat_r <= is_io ? io_in : mem[idx]; // i/o reads the port.
    end

endmodule

//--- hdl/lsu_wb_master.sv
`timescale 1ns/1ns

module lsu_wb_master (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  lsu_pkg::lsu_bus_req_t in_req,
    output logic                  out_valid,
    input  logic                  out_ready,
    output lsu_pkg::lsu_bus_rsp_t out_rsp,
    output logic                  wb_cyc,
    output logic                  wb_stb,
    output logic                  wb_we,
    output logic [29:0]           wb_adr,
    output logic [3:0]            wb_sel,
    output logic [31:0]           wb_dat_w,
    input  logic [31:0]           wb_dat_r,
    input  logic                  wb_ack
);
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUS,
        ST_RESP
    } state_e;

    state_e state;
    logic   in_fire;

    assign in_ready  = (state == ST_IDLE);
    assign out_valid = (state == ST_RESP);
    assign in_fire   = in_valid && in_ready;

    ////////////////////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state  <= ST_IDLE;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                    if (in_fire)
                    begin
                        if (in_req.fault)
                            state <= ST_RESP; // no bus cycle.
                        else
                        begin
                            state  <= ST_BUS;
                            wb_cyc <= 1'b1;
                            wb_stb <= 1'b1;
                        end
                    end
                ST_BUS:
                    if (wb_ack)
                    begin
                        state  <= ST_RESP;
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                    end
                default:
                    if (out_ready)
                        state <= ST_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // bus and response payload
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (in_fire)
        begin
            wb_we          <= in_req.we;
            wb_adr         <= in_req.word_adr;
            wb_sel         <= in_req.sel;
            wb_dat_w       <= in_req.wdata;
            out_rsp.op     <= in_req.op;
            out_rsp.offset <= in_req.offset;
            out_rsp.fault  <= in_req.fault;
            out_rsp.rdata  <= '0;
        end
        else if (state == ST_BUS && wb_ack)
            out_rsp.rdata <= wb_dat_r;
    end

endmodule

//--- hdl/lsu_skid_buffer.sv
`timescale 1ns/1ns

module lsu_skid_buffer #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);
    logic     skid_valid;
    payload_t skid_data;
    logic     in_fire;
    logic     out_free;

    // ready comes from a flop, never from out_ready.
    assign in_ready = !skid_valid;
    assign in_fire  = in_valid && in_ready;
    assign out_free = !out_valid || out_ready;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end
        else if (out_free)
        begin
            if (skid_valid)
            begin
                out_valid  <= 1'b1; // drain the skid slot first.
                skid_valid <= 1'b0;
            end
            else
                out_valid <= in_fire;
        end
        else if (in_fire)
            skid_valid <= 1'b1; // output stalled, park it.
    end

    always_ff @(posedge clk)
    begin
        if (out_free)
        begin
            if (skid_valid)
                out_data <= skid_data;
            else if (in_fire)
                out_data <= in_data;
        end
        else if (in_fire)
            skid_data <= in_data;
    end

endmodule

//--- hdl/lsu_align.sv
`timescale 1ns/1ns

module lsu_align (
    input  logic                  in_valid,
    output logic                  in_ready,
    input  lsu_pkg::lsu_req_t     in_req,
    output logic                  out_valid,
    input  logic                  out_ready,
    output lsu_pkg::lsu_bus_req_t out_req
);
    import lsu_pkg::*;

    logic        is_byte;
    logic        is_half;
    logic        is_store;
    logic [1:0]  offset;
    logic        misaligned;
    logic [3:0]  sel;
    logic [31:0] lane_data;

    // pure decode, handshake passes straight through.
    assign out_valid = in_valid;
    assign in_ready  = out_ready;

    assign offset = in_req.addr[1:0];

    always_comb
    begin
        is_byte  = 1'b0;
        is_half  = 1'b0;
        is_store = 1'b0;
        case (in_req.op)
            LB, LBU:
                is_byte = 1'b1;
            LH, LHU:
                is_half = 1'b1;
            SB:
            begin
                is_byte  = 1'b1;
                is_store = 1'b1;
            end
            SH:
            begin
                is_half  = 1'b1;
                is_store = 1'b1;
            end
            SW:
                is_store = 1'b1;
            default:
                is_store = 1'b0; // LW.
        endcase
    end

    // halfword needs even, word needs 4-aligned.
    assign misaligned = is_half ? offset[0] : (!is_byte && (offset != 2'b00));

    always_comb
    begin
        if (is_byte)
        begin
            sel       = 4'b0001 << offset;
            lane_data = {24'b0, in_req.wdata[7:0]} << {offset, 3'b000};
        end
        else if (is_half)
        begin
            sel       = 4'b0011 << offset;
            lane_data = {16'b0, in_req.wdata[15:0]} << {offset, 3'b000};
        end
        else
        begin
            sel       = 4'b1111;
            lane_data = in_req.wdata;
        end
    end

    always_comb
    begin
        out_req.word_adr = in_req.addr[31:2];
        out_req.op       = in_req.op;
        out_req.offset   = offset;
        out_req.fault    = misaligned;
        out_req.sel      = misaligned ? 4'b0000 : sel;
        out_req.we       = is_store && !misaligned;
        out_req.wdata    = misaligned ? '0 : lane_data;
    end

endmodule

//--- hdl/lsu_pkg.sv
`include "lsu_consts.svh"

package lsu_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // operations
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW
    } lsu_op_e;

    ////////////////////////////////////////////////////////////////////////////
    // payloads
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        lsu_op_e               op;
        logic [31:0]           addr;
        logic [`LSU_XLEN-1:0]  wdata;
    } lsu_req_t;

    typedef struct packed {
        logic [29:0]           word_adr;  // byte address without offset.
        logic [3:0]            sel;
        logic                  we;
        logic [`LSU_XLEN-1:0]  wdata;     // already in its lanes.
        lsu_op_e               op;
        logic [1:0]            offset;
        logic                  fault;
    } lsu_bus_req_t;

    typedef struct packed {
        logic [`LSU_XLEN-1:0]  rdata;     // raw word from the bus.
        lsu_op_e               op;
        logic [1:0]            offset;
        logic                  fault;
    } lsu_bus_rsp_t;

    typedef struct packed {
        logic [`LSU_XLEN-1:0]  data;
        logic                  fault;
    } lsu_rsp_t;

endpackage

//--- hdl/lsu_consts.svh
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// memory and bus sizing
////////////////////////////////////////////////////////////////////////////

// data memory depth in 32-bit words, addresses wrap.
`define LSU_MEM_WORDS 1024

// lowest byte address of the input port window.
`define LSU_IO_BASE 32'hFFFF0000

// data path width.
`define LSU_XLEN 32

`endif
